/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module cpu -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
hdl/cpu_pkg.sv
hdl/dmem_if.sv
hdl/control_unit.sv
hdl/imm_decode.sv
hdl/register_file.sv
hdl/alu.sv
hdl/data_mem.sv
hdl/cpu.sv
sim/cpu_sva.sv
sim/cpu_tb.sv

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t          op,
    input  logic [cpu_pkg::XLEN-1:0]  a,
    input  logic [cpu_pkg::XLEN-1:0]  b,
    output logic [cpu_pkg::XLEN-1:0]  result,
    output logic                      less,
    output logic                      zero
);

    localparam int SHW = $clog2(cpu_pkg::XLEN);

    logic [SHW-1:0] shamt;

    // only the low bits of b shift
    assign shamt = b[SHW-1:0];

    // unsigned only for sltu
    assign less = (op == cpu_pkg::ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:    result = a + b;
            cpu_pkg::ALU_SUB:    result = a - b;
            cpu_pkg::ALU_SLL:    result = a << shamt;
            cpu_pkg::ALU_SRL:    result = a >> shamt;
            cpu_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            // compare results are 0 or 1
            cpu_pkg::ALU_SLT,
            cpu_pkg::ALU_SLTU:   result = {{(cpu_pkg::XLEN-1){1'b0}}, less};
            cpu_pkg::ALU_XOR:    result = a ^ b;
            cpu_pkg::ALU_OR:     result = a | b;
            cpu_pkg::ALU_AND:    result = a & b;
            // lui path
            cpu_pkg::ALU_PASS_B: result = b;
            default:             result = a + b;
        endcase
    end

    // beq/bne look at this after sub
    assign zero = (result == '0);

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic [6:0]            opcode,
    input  logic [2:0]            funct3,
    input  logic                  funct7_5,
    input  logic                  less,
    input  logic                  zero,
    output cpu_pkg::imm_fmt_t     imm_fmt,
    output logic                  reg_wen,
    output logic                  load,
    output logic                  store,
    output cpu_pkg::load_ext_t    load_ext,
    output logic [1:0]            store_size,
    output cpu_pkg::alu_a_sel_t   alu_a_sel,
    output cpu_pkg::alu_b_sel_t   alu_b_sel,
    output cpu_pkg::alu_op_t      alu_op,
    output cpu_pkg::pc_base_sel_t pc_base_sel,
    output cpu_pkg::pc_off_sel_t  pc_off_sel
);

    // arithmetic op from funct3
    // alt picks sub or sra, use_sub only set for register-register ops
    function automatic cpu_pkg::alu_op_t arith_op(input logic [2:0] f3, input logic alt,
                                                   input logic use_sub);
        cpu_pkg::alu_op_t op;
        case (f3)
            cpu_pkg::F3_ADD:  op = (alt && use_sub) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            cpu_pkg::F3_SLL:  op = cpu_pkg::ALU_SLL;
            cpu_pkg::F3_SLT:  op = cpu_pkg::ALU_SLT;
            cpu_pkg::F3_SLTU: op = cpu_pkg::ALU_SLTU;
            cpu_pkg::F3_XOR:  op = cpu_pkg::ALU_XOR;
            cpu_pkg::F3_SR:   op = alt ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            cpu_pkg::F3_OR:   op = cpu_pkg::ALU_OR;
            default:          op = cpu_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    logic taken;

    // branch condition from the alu flags
    always_comb begin
        case (funct3)
            cpu_pkg::F3_BEQ:  taken = zero;
            cpu_pkg::F3_BNE:  taken = !zero;
            cpu_pkg::F3_BLT,
            cpu_pkg::F3_BLTU: taken = less;
            cpu_pkg::F3_BGE,
            cpu_pkg::F3_BGEU: taken = !less;
            default:          taken = 1'b0;
        endcase
    end

    always_comb begin
        // no writes and pc+4 unless the opcode says otherwise
        imm_fmt     = cpu_pkg::IMM_I;
        reg_wen     = 1'b0;
        load        = 1'b0;
        store       = 1'b0;
        load_ext    = cpu_pkg::load_ext_t'(funct3);
        store_size  = funct3[1:0];
        alu_a_sel   = cpu_pkg::A_RS1;
        alu_b_sel   = cpu_pkg::B_RS2;
        alu_op      = cpu_pkg::ALU_ADD;
        pc_base_sel = cpu_pkg::BASE_PC;
        pc_off_sel  = cpu_pkg::OFF_FOUR;
        case (opcode)
            cpu_pkg::OPC_LUI: begin
                imm_fmt   = cpu_pkg::IMM_U;
                reg_wen   = 1'b1;
                alu_b_sel = cpu_pkg::B_IMM;
                alu_op    = cpu_pkg::ALU_PASS_B;
            end
            cpu_pkg::OPC_AUIPC: begin
                imm_fmt   = cpu_pkg::IMM_U;
                reg_wen   = 1'b1;
                alu_a_sel = cpu_pkg::A_PC;
                alu_b_sel = cpu_pkg::B_IMM;
            end
            // link value pc+4 comes out of the alu
            cpu_pkg::OPC_JAL: begin
                imm_fmt    = cpu_pkg::IMM_J;
                reg_wen    = 1'b1;
                alu_a_sel  = cpu_pkg::A_PC;
                alu_b_sel  = cpu_pkg::B_FOUR;
                pc_off_sel = cpu_pkg::OFF_IMM;
            end
            cpu_pkg::OPC_JALR: begin
                reg_wen     = 1'b1;
                alu_a_sel   = cpu_pkg::A_PC;
                alu_b_sel   = cpu_pkg::B_FOUR;
                pc_base_sel = cpu_pkg::BASE_RS1;
                pc_off_sel  = cpu_pkg::OFF_IMM;
            end
            cpu_pkg::OPC_BRANCH: begin
                imm_fmt = cpu_pkg::IMM_B;
                // eq/ne compare by subtraction
                if (funct3[2:1] == 2'b00)
                    alu_op = cpu_pkg::ALU_SUB;
                else if (funct3[1])
                    alu_op = cpu_pkg::ALU_SLTU;
                else
                    alu_op = cpu_pkg::ALU_SLT;
                pc_off_sel = taken ? cpu_pkg::OFF_IMM : cpu_pkg::OFF_FOUR;
            end
            cpu_pkg::OPC_LOAD: begin
                reg_wen   = 1'b1;
                load      = 1'b1;
                alu_b_sel = cpu_pkg::B_IMM;
            end
            cpu_pkg::OPC_STORE: begin
                imm_fmt   = cpu_pkg::IMM_S;
                store     = 1'b1;
                alu_b_sel = cpu_pkg::B_IMM;
            end
            cpu_pkg::OPC_OP_IMM: begin
                reg_wen   = 1'b1;
                alu_b_sel = cpu_pkg::B_IMM;
                alu_op    = arith_op(funct3, funct7_5, 1'b0);
            end
            cpu_pkg::OPC_OP: begin
                reg_wen = 1'b1;
                alu_op  = arith_op(funct3, funct7_5, 1'b1);
            end
            default: ;
        endcase
    end

endmodule

/* hdl/cpu.sv */
`timescale 1ns/1ps

module cpu #(
    parameter logic [31:0] RESET_PC   = cpu_pkg::DEFAULT_RESET_PC,
    parameter int          DMEM_WORDS = cpu_pkg::DEFAULT_DMEM_WORDS,
    parameter int          NREGS      = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] cmd,
    output logic [31:0] pc,
    output logic [31:0] dnpc
);

    localparam int RAW = $clog2(NREGS);

    // register indices straight from the instruction word
    logic [RAW-1:0] rs1, rs2, rd;

    logic [31:0] src1, src2, imm;
    logic [31:0] alu_a, alu_b, alu_result;
    logic [31:0] pc_base, pc_off, pc_sum;
    logic [31:0] load_word, load_data, wb_data;
    logic [1:0]  byte_off;
    logic        less, zero;
    logic        reg_wen, load, store;
    logic [1:0]  store_size;

    cpu_pkg::imm_fmt_t     imm_fmt;
    cpu_pkg::load_ext_t    load_ext;
    cpu_pkg::alu_a_sel_t   alu_a_sel;
    cpu_pkg::alu_b_sel_t   alu_b_sel;
    cpu_pkg::alu_op_t      alu_op;
    cpu_pkg::pc_base_sel_t pc_base_sel;
    cpu_pkg::pc_off_sel_t  pc_off_sel;

    dmem_if dbus ();

    assign rs1 = cmd[15 +: RAW];
    assign rs2 = cmd[20 +: RAW];
    assign rd  = cmd[7 +: RAW];

    control_unit cu_i (
        .opcode      (cmd[6:0]),
        .funct3      (cmd[14:12]),
        .funct7_5    (cmd[30]),
        .less        (less),
        .zero        (zero),
        .imm_fmt     (imm_fmt),
        .reg_wen     (reg_wen),
        .load        (load),
        .store       (store),
        .load_ext    (load_ext),
        .store_size  (store_size),
        .alu_a_sel   (alu_a_sel),
        .alu_b_sel   (alu_b_sel),
        .alu_op      (alu_op),
        .pc_base_sel (pc_base_sel),
        .pc_off_sel  (pc_off_sel)
    );

    imm_decode imm_i (
        .cmd     (cmd),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    // no register write while in reset
    register_file #(.NREGS(NREGS)) rf_i (
        .clk     (clk),
        .raddr_a (rs1),
        .raddr_b (rs2),
        .waddr   (rd),
        .wdata   (wb_data),
        .wen     (reg_wen && !rst),
        .rdata_a (src1),
        .rdata_b (src2)
    );

    // alu operand muxes
    assign alu_a = (alu_a_sel == cpu_pkg::A_PC) ? pc : src1;

    always_comb begin
        case (alu_b_sel)
            cpu_pkg::B_IMM:  alu_b = imm;
            cpu_pkg::B_FOUR: alu_b = 32'd4;
            default:         alu_b = src2;
        endcase
    end

    alu alu_i (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .less   (less),
        .zero   (zero)
    );

    // next pc adder
    assign pc_base = (pc_base_sel == cpu_pkg::BASE_RS1) ? src1 : pc;
    assign pc_off  = (pc_off_sel == cpu_pkg::OFF_IMM) ? imm : 32'd4;
    assign pc_sum  = pc_base + pc_off;
    // jalr target has bit 0 cleared
    assign dnpc    = {pc_sum[31:1], pc_sum[0] && (pc_base_sel != cpu_pkg::BASE_RS1)};

    always_ff @(posedge clk) begin
        if (rst)
            pc <= RESET_PC;
        else
            pc <= dnpc;
    end

    // byte offset inside the addressed word
    assign byte_off = alu_result[1:0];

    // memory request, held off under reset
    assign dbus.valid = (load || store) && !rst;
    assign dbus.wen   = store;
    assign dbus.addr  = alu_result;
    // rs2 moved up into its byte lanes
    assign dbus.wdata = src2 << {byte_off, 3'b000};

    always_comb begin
        case (store_size)
            cpu_pkg::ST_B: dbus.wmask = 4'b0001 << byte_off;
            cpu_pkg::ST_H: dbus.wmask = 4'b0011 << byte_off;
            default:       dbus.wmask = 4'b1111;
        endcase
    end

    data_mem #(.WORDS(DMEM_WORDS)) dmem_i (
        .clk (clk),
        .bus (dbus)
    );

    // addressed byte or half down to bit 0
    assign load_word = dbus.rdata >> {byte_off, 3'b000};

    always_comb begin
        case (load_ext)
            cpu_pkg::LD_B:  load_data = {{24{load_word[7]}}, load_word[7:0]};
            cpu_pkg::LD_H:  load_data = {{16{load_word[15]}}, load_word[15:0]};
            cpu_pkg::LD_BU: load_data = {24'h000000, load_word[7:0]};
            cpu_pkg::LD_HU: load_data = {16'h0000, load_word[15:0]};
            default:        load_data = load_word;
        endcase
    end

    // write-back select
    assign wb_data = load ? load_data : alu_result;

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    // data and address width
    localparam int XLEN = 32;

    // reset defaults, overridable at the top level
    localparam logic [XLEN-1:0] DEFAULT_RESET_PC   = 32'h8000_0000;
    localparam int              DEFAULT_DMEM_WORDS = 1024;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // arithmetic funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // store width, low two bits of funct3
    localparam logic [1:0] ST_B = 2'b00;
    localparam logic [1:0] ST_H = 2'b01;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_OR, ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_t;

    // operand and next-pc selects
    typedef enum logic       {A_RS1, A_PC} alu_a_sel_t;
    typedef enum logic [1:0] {B_RS2, B_IMM, B_FOUR} alu_b_sel_t;
    typedef enum logic       {BASE_PC, BASE_RS1} pc_base_sel_t;
    typedef enum logic       {OFF_FOUR, OFF_IMM} pc_off_sel_t;

    // load extraction, same encoding as load funct3
    typedef enum logic [2:0] {
        LD_B  = 3'b000,
        LD_H  = 3'b001,
        LD_W  = 3'b010,
        LD_BU = 3'b100,
        LD_HU = 3'b101
    } load_ext_t;

endpackage

/* hdl/data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
    parameter int WORDS = cpu_pkg::DEFAULT_DMEM_WORDS
) (
    input logic   clk,
    dmem_if.mem   bus
);

    localparam int AW = $clog2(WORDS);

    logic [cpu_pkg::XLEN-1:0] mem [WORDS];
    logic [AW-1:0]            index;
    logic                     do_write;

    // word index, wraps at the array size
    assign index = bus.addr[AW+1:2];

    assign do_write = bus.valid && bus.wen;

    // one write enable per byte lane
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (do_write && bus.wmask[lane])
                mem[index][lane*8 +: 8] <= bus.wdata[lane*8 +: 8];
        end
    end

    // raw word, lane selection is done in the core
    assign bus.rdata = mem[index];

endmodule

/* hdl/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if;

    // request side, driven by the core
    logic                      valid;
    logic                      wen;
    logic [cpu_pkg::XLEN-1:0]  addr;
    logic [cpu_pkg::XLEN-1:0]  wdata;
    logic [3:0]                wmask;
    // raw word back from memory
    logic [cpu_pkg::XLEN-1:0]  rdata;

    modport core (output valid, output wen, output addr, output wdata, output wmask,
                  input rdata);

    modport mem (input valid, input wen, input addr, input wdata, input wmask,
                 output rdata);

endinterface

/* hdl/imm_decode.sv */
`timescale 1ns/1ps

module imm_decode (
    input  logic [31:0]               cmd,
    input  cpu_pkg::imm_fmt_t         imm_fmt,
    output logic [cpu_pkg::XLEN-1:0]  imm
);

    always_comb begin
        case (imm_fmt)
            // store offset split over rd and funct7 fields
            cpu_pkg::IMM_S:
                imm = {{20{cmd[31]}}, cmd[31:25], cmd[11:7]};
            // branch offset, bit 0 always zero
            cpu_pkg::IMM_B:
                imm = {{19{cmd[31]}}, cmd[31], cmd[7], cmd[30:25], cmd[11:8], 1'b0};
            // upper 20 bits
            cpu_pkg::IMM_U:
                imm = {cmd[31:12], 12'h000};
            // jal offset
            cpu_pkg::IMM_J:
                imm = {{11{cmd[31]}}, cmd[31], cmd[19:12], cmd[20], cmd[30:21], 1'b0};
            // i-type and anything unexpected
            default:
                imm = {{20{cmd[31]}}, cmd[31:20]};
        endcase
    end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file #(
    parameter int NREGS = 32
) (
    input  logic                      clk,
    input  logic [$clog2(NREGS)-1:0]  raddr_a,
    input  logic [$clog2(NREGS)-1:0]  raddr_b,
    input  logic [$clog2(NREGS)-1:0]  waddr,
    input  logic [cpu_pkg::XLEN-1:0]  wdata,
    input  logic                      wen,
    output logic [cpu_pkg::XLEN-1:0]  rdata_a,
    output logic [cpu_pkg::XLEN-1:0]  rdata_b
);

    logic [cpu_pkg::XLEN-1:0] regs [NREGS];

    // x0 never written
    always_ff @(posedge clk) begin
        if (wen && waddr != '0)
            regs[waddr] <= wdata;
    end

    // x0 reads as zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

/* sim/cpu_sva.sv */
`timescale 1ns/1ps

module cpu_sva #(
    parameter logic [31:0] RESET_PC = 32'h8000_0000
) (
    input logic        clk,
    input logic        rst,
    input logic [31:0] pc,
    input logic [31:0] dnpc
);

    // pc follows the next-pc value of the previous cycle
    property pc_follows_dnpc;
        @(posedge clk) !rst |=> (pc == $past(dnpc));
    endproperty

    // a reset edge loads the reset vector
    property pc_reset_value;
        @(posedge clk) rst |=> (pc == RESET_PC);
    endproperty

    // instructions are always word aligned
    property pc_word_aligned;
        @(posedge clk) disable iff (rst) (pc[1:0] == 2'b00);
    endproperty

    pc_seq_a: assert property (pc_follows_dnpc)
        else $error("pc does not match the previous dnpc");

    pc_rst_a: assert property (pc_reset_value)
        else $error("pc is not the reset vector after reset");

    pc_align_a: assert property (pc_word_aligned)
        else $error("pc is not word aligned");

endmodule

bind cpu cpu_sva #(.RESET_PC(RESET_PC)) cpu_sva_i (
    .clk  (clk),
    .rst  (rst),
    .pc   (pc),
    .dnpc (dnpc)
);

/* sim/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam logic [31:0] RESET_PC = cpu_pkg::DEFAULT_RESET_PC;
    localparam int          PROG_LEN = 96;
    localparam int          MAX_CYCLES = 400;
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic        clk;
    logic        rst;
    logic [31:0] cmd;
    logic [31:0] pc;
    logic [31:0] dnpc;

    // program image and architectural state
    logic [31:0] prog [PROG_LEN];
    logic [31:0] xr [32];
    logic [7:0]  dbytes [4096];
    logic [31:0] mpc;
    logic [31:0] end_addr;
    int          cycles;

    cpu #(.RESET_PC(RESET_PC)) cpu_i (
        .clk  (clk),
        .rst  (rst),
        .cmd  (cmd),
        .pc   (pc),
        .dnpc (dnpc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction encoders in base ISA field order
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // reference arithmetic from the instruction semantics
    function automatic logic [31:0] ref_arith(input logic [2:0] f3, input logic [31:0] a,
                                              input logic [31:0] b, input logic alt);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic build_program();
        int          n;
        int          kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  ra;
        logic [4:0]  rb;
        n = 0;
        // signed and unsigned compares across the sign boundary
        prog[n++] = enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'h13);
        prog[n++] = {20'h80000, 5'd2, 7'h37};
        prog[n++] = enc_i(12'hfff, 5'd0, 3'd0, 5'd3, 7'h13);
        prog[n++] = enc_b(13'd8, 5'd3, 5'd2, 3'd4);
        prog[n++] = NOP;
        prog[n++] = enc_b(13'd8, 5'd2, 5'd3, 3'd6);
        prog[n++] = enc_b(13'd8, 5'd2, 5'd3, 3'd5);
        prog[n++] = NOP;
        prog[n++] = enc_b(13'd8, 5'd3, 5'd2, 3'd7);
        // same four compares with the operands swapped
        prog[n++] = enc_b(13'd8, 5'd2, 5'd3, 3'd4);
        prog[n++] = enc_b(13'd8, 5'd3, 5'd2, 3'd6);
        prog[n++] = NOP;
        prog[n++] = enc_b(13'd8, 5'd3, 5'd2, 3'd5);
        prog[n++] = enc_b(13'd8, 5'd2, 5'd3, 3'd7);
        prog[n++] = NOP;
        prog[n++] = enc_b(13'd8, 5'd1, 5'd1, 3'd0);
        prog[n++] = NOP;
        prog[n++] = enc_b(13'd8, 5'd1, 5'd1, 3'd1);
        // write of 5 to x0 is dropped and beq x0 x1 falls through
        prog[n++] = enc_i(12'd5, 5'd0, 3'd0, 5'd0, 7'h13);
        prog[n++] = enc_b(13'd8, 5'd1, 5'd0, 3'd0);
        // jal links into x4 and jalr returns through it with bit 0 set
        prog[n++] = enc_j(21'd8, 5'd4);
        prog[n++] = NOP;
        prog[n++] = enc_i(12'd13, 5'd4, 3'd0, 5'd0, 7'h67);
        prog[n++] = NOP;
        // store widths then every load width
        prog[n++] = enc_i(12'h100, 5'd0, 3'd0, 5'd10, 7'h13);
        prog[n++] = enc_s(12'd0, 5'd3, 5'd10, 3'd2);
        prog[n++] = enc_i(12'h080, 5'd0, 3'd0, 5'd5, 7'h13);
        prog[n++] = enc_s(12'd1, 5'd5, 5'd10, 3'd0);
        prog[n++] = enc_i(12'h234, 5'd0, 3'd0, 5'd6, 7'h13);
        prog[n++] = enc_s(12'd2, 5'd6, 5'd10, 3'd1);
        prog[n++] = enc_i(12'd1, 5'd10, 3'd0, 5'd7, 7'h03);
        prog[n++] = enc_i(12'd1, 5'd10, 3'd4, 5'd8, 7'h03);
        prog[n++] = enc_i(12'd2, 5'd10, 3'd1, 5'd9, 7'h03);
        prog[n++] = enc_i(12'd0, 5'd10, 3'd5, 5'd11, 7'h03);
        prog[n++] = enc_i(12'd0, 5'd10, 3'd2, 5'd12, 7'h03);
        // loaded values against the stored registers
        prog[n++] = enc_b(13'd8, 5'd8, 5'd7, 3'd1);
        prog[n++] = NOP;
        prog[n++] = enc_b(13'd8, 5'd5, 5'd8, 3'd0);
        prog[n++] = NOP;
        prog[n++] = enc_b(13'd8, 5'd6, 5'd9, 3'd0);
        prog[n++] = NOP;
        // x14 rebuilt as the expected low half 0x80ff
        prog[n++] = enc_i(12'd8, 5'd5, 3'd1, 5'd14, 7'h13);
        prog[n++] = enc_i(12'h0ff, 5'd14, 3'd0, 5'd14, 7'h13);
        prog[n++] = enc_b(13'd8, 5'd14, 5'd11, 3'd0);
        prog[n++] = NOP;
        // x15 rebuilt as the expected word 0x023480ff
        prog[n++] = enc_i(12'd16, 5'd6, 3'd1, 5'd15, 7'h13);
        prog[n++] = enc_r(7'd0, 5'd14, 5'd15, 3'd0, 5'd15);
        prog[n++] = enc_b(13'd8, 5'd15, 5'd12, 3'd0);
        prog[n++] = NOP;
        prog[n++] = {20'h00001, 5'd13, 7'h17};
        // random alu and forward branch mix
        for (int k = 0; k < 40; k++) begin
            kind = $urandom % 5;
            f3   = 3'($urandom);
            rd   = 5'($urandom % 14);
            ra   = 5'($urandom % 14);
            rb   = 5'($urandom % 14);
            case (kind)
                0: prog[n++] = enc_i(12'($urandom), ra, f3, rd, 7'h13);
                1: prog[n++] = enc_r({1'b0, ($urandom % 2 == 1) && (f3 == 0 || f3 == 5),
                                      5'd0}, rb, ra, f3, rd);
                2: prog[n++] = {20'($urandom), rd, ($urandom % 2 == 1) ? 7'h37 : 7'h17};
                default: prog[n++] = enc_b(13'd8, rb, ra, (f3 == 2 || f3 == 3) ? 3'd0 : f3);
            endcase
        end
        prog[n++] = NOP;
        end_addr = RESET_PC + 32'(n * 4);
        prog[n++] = enc_j(21'd0, 5'd0);
        while (n < PROG_LEN)
            prog[n++] = NOP;
    endtask

    // one architectural step giving the expected next pc
    task automatic execute(input logic [31:0] ins, output logic [31:0] npc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immi;
        logic [31:0] res;
        logic [31:0] addr;
        logic [11:0] ma;
        logic        wr;
        logic        cond;
        a    = xr[ins[19:15]];
        b    = xr[ins[24:20]];
        immi = {{20{ins[31]}}, ins[31:20]};
        npc  = mpc + 32'd4;
        wr   = 1'b1;
        res  = '0;
        case (ins[6:0])
            7'h37: res = {ins[31:12], 12'd0};
            7'h17: res = mpc + {ins[31:12], 12'd0};
            7'h6f: begin
                res = mpc + 32'd4;
                npc = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                res = mpc + 32'd4;
                npc = (a + immi) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                case (ins[14:12])
                    3'd0:    cond = (a == b);
                    3'd1:    cond = (a != b);
                    3'd4:    cond = ($signed(a) < $signed(b));
                    3'd5:    cond = ($signed(a) >= $signed(b));
                    3'd6:    cond = (a < b);
                    default: cond = (a >= b);
                endcase
                if (cond)
                    npc = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            7'h03: begin
                addr = a + immi;
                ma   = addr[11:0];
                case (ins[14:12])
                    3'd0:    res = {{24{dbytes[ma][7]}}, dbytes[ma]};
                    3'd4:    res = {24'd0, dbytes[ma]};
                    3'd1:    res = {{16{dbytes[ma+1][7]}}, dbytes[ma+1], dbytes[ma]};
                    3'd5:    res = {16'd0, dbytes[ma+1], dbytes[ma]};
                    default: res = {dbytes[ma+3], dbytes[ma+2], dbytes[ma+1], dbytes[ma]};
                endcase
            end
            7'h23: begin
                wr   = 1'b0;
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                ma   = addr[11:0];
                for (int i = 0; i < (1 << ins[13:12]); i++)
                    dbytes[ma + 12'(i)] = b[i*8 +: 8];
            end
            7'h13: res = ref_arith(ins[14:12], a, immi, ins[30] && ins[14:12] == 3'd5);
            7'h33: res = ref_arith(ins[14:12], a, b, ins[30]);
            default: wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0)
            xr[ins[11:7]] = res;
        mpc = npc;
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    initial begin
        logic [31:0] exp_npc;
        int          idx;
        rst = 1'b1;
        cmd = NOP;
        void'($urandom(41));
        build_program();
        for (int i = 0; i < 32; i++)
            xr[i] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        mpc = RESET_PC;
        assert (pc === RESET_PC)
        else fail_now($sformatf("error pc: got %h expected %h", pc, RESET_PC));
        cycles = 0;
        while (mpc != end_addr) begin
            cycles++;
            if (cycles > MAX_CYCLES)
                fail_now("timeout: program did not reach its end");
            idx = int'((pc - RESET_PC) >> 2);
            if (idx >= PROG_LEN)
                fail_now("pc left the program image");
            cmd = prog[idx];
            #1;
            execute(cmd, exp_npc);
            assert (dnpc === exp_npc)
            else fail_now($sformatf("error dnpc: got %h expected %h", dnpc, exp_npc));
            @(posedge clk);
            #1;
        end
        if (pc === end_addr) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("error pc: got %h expected %h", pc, end_addr);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

endmodule
